//--- design/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 8;
    localparam int tag_w = 3;

    // architectural field widths
    localparam int reg_w = 5;
    localparam int data_w = 32;
    localparam int addr_w = 32;

    // instruction class carried with each entry
    typedef enum logic [1:0] {
        // writes its result to rd
        op_alu = 2'd0,
        // released to the store unit, no register write
        op_store = 2'd1,
        // writes link value to rd, checked against prediction
        op_branch = 2'd2
    } rob_op_e;

    // input side four-phase handshake
    typedef enum logic {
        disp_idle,
        disp_ack_high
    } dispatch_state_e;

    // output side four-phase handshake
    typedef enum logic [1:0] {
        cm_idle,
        cm_req_high,
        cm_wait_ack_low
    } commit_state_e;

endpackage

//--- design/rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch (
    input  logic clk,
    input  logic rst_n,
    input  logic disp_req,
    input  logic full,
    input  logic flush,
    output logic disp_ack,
    output logic alloc_en
);

    rob_pkg::dispatch_state_e state;
    rob_pkg::dispatch_state_e state_next;

    // take a new request only from idle, with room and no flush in flight
    assign alloc_en = (state == rob_pkg::disp_idle) && disp_req && !full && !flush;

    // ack follows the state, so it rises on the allocation edge
    assign disp_ack = (state == rob_pkg::disp_ack_high);

    always_comb begin
        state_next = state;
        case (state)
            rob_pkg::disp_idle: begin
                if (alloc_en) begin
                    state_next = rob_pkg::disp_ack_high;
                end
            end
            rob_pkg::disp_ack_high: begin
                // hold ack until the source drops its request
                if (!disp_req) begin
                    state_next = rob_pkg::disp_idle;
                end
            end
            default: begin
                state_next = rob_pkg::disp_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rob_pkg::disp_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- design/rob_buffer.sv
`timescale 1ns/1ps

module rob_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    // allocation from the input side
    input  logic                       alloc_en,
    input  rob_pkg::rob_op_e           alloc_op,
    input  logic [rob_pkg::reg_w-1:0]  alloc_rd,
    input  logic                       alloc_pred_taken,
    output logic [rob_pkg::tag_w-1:0]  alloc_tag,
    output logic                       full,
    // completion write-back
    input  logic                       cmp_valid,
    input  logic [rob_pkg::tag_w-1:0]  cmp_tag,
    input  logic [rob_pkg::data_w-1:0] cmp_data,
    input  logic                       cmp_taken,
    input  logic [rob_pkg::addr_w-1:0] cmp_next_pc,
    // head view and control from the output side
    input  logic                       retire,
    input  logic                       flush,
    output logic                       head_ready,
    output logic [rob_pkg::tag_w-1:0]  head_tag,
    output rob_pkg::rob_op_e           head_op,
    output logic [rob_pkg::reg_w-1:0]  head_rd,
    output logic [rob_pkg::data_w-1:0] head_data,
    output logic                       head_mispredict,
    output logic [rob_pkg::addr_w-1:0] head_next_pc
);

    // per-entry status
    logic [rob_pkg::rob_depth-1:0] occupied;
    logic [rob_pkg::rob_depth-1:0] done;

    // per-entry payload
    rob_pkg::rob_op_e           op_q      [rob_pkg::rob_depth];
    logic [rob_pkg::reg_w-1:0]  rd_q      [rob_pkg::rob_depth];
    logic [rob_pkg::data_w-1:0] data_q    [rob_pkg::rob_depth];
    logic                       pred_q    [rob_pkg::rob_depth];
    logic                       actual_q  [rob_pkg::rob_depth];
    logic [rob_pkg::addr_w-1:0] next_pc_q [rob_pkg::rob_depth];

    logic [rob_pkg::tag_w-1:0] head;
    logic [rob_pkg::tag_w-1:0] tail;
    logic [rob_pkg::tag_w:0]   count;
    logic                      cmp_hit;

    // stale tags from before a flush find no occupied slot
    assign cmp_hit = cmp_valid && occupied[cmp_tag];

    assign full = (count == (rob_pkg::tag_w + 1)'(rob_pkg::rob_depth));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else if (flush) begin
            // drop everything, restart tags at zero
            occupied <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (alloc_en) begin
                occupied[tail] <= 1'b1;
                done[tail]     <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (cmp_hit) begin
                done[cmp_tag] <= 1'b1;
            end
            // retire last so it wins over a late completion to the head
            if (retire) begin
                occupied[head] <= 1'b0;
                done[head]     <= 1'b0;
                head           <= head + 1'b1;
            end
            if (alloc_en && !retire) begin
                count <= count + 1'b1;
            end else if (!alloc_en && retire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            op_q[tail]   <= alloc_op;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred_taken;
            // tag stays visible while the input side holds ack high
            alloc_tag    <= tail;
        end
        if (cmp_hit) begin
            data_q[cmp_tag]    <= cmp_data;
            actual_q[cmp_tag]  <= cmp_taken;
            next_pc_q[cmp_tag] <= cmp_next_pc;
        end
    end

    // head view for the output side
    assign head_ready   = occupied[head] && done[head];
    assign head_tag     = head;
    assign head_op      = op_q[head];
    assign head_rd      = rd_q[head];
    assign head_data    = data_q[head];
    assign head_next_pc = next_pc_q[head];

    // only branches can mispredict
    assign head_mispredict = (op_q[head] == rob_pkg::op_branch) &&
                             (pred_q[head] != actual_q[head]);

endmodule

//--- design/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  logic                       clk,
    input  logic                       rst_n,
    // head view from the buffer
    input  logic                       head_ready,
    input  logic [rob_pkg::tag_w-1:0]  head_tag,
    input  rob_pkg::rob_op_e           head_op,
    input  logic [rob_pkg::reg_w-1:0]  head_rd,
    input  logic [rob_pkg::data_w-1:0] head_data,
    input  logic                       head_mispredict,
    input  logic [rob_pkg::addr_w-1:0] head_next_pc,
    // commit port
    output logic                       cm_req,
    input  logic                       cm_ack,
    output logic [rob_pkg::tag_w-1:0]  cm_tag,
    output logic [rob_pkg::reg_w-1:0]  cm_rd,
    output logic [rob_pkg::data_w-1:0] cm_data,
    output logic                       cm_store,
    // back to the buffer and out to fetch
    output logic                       retire,
    output logic                       flush,
    output logic [rob_pkg::addr_w-1:0] redirect_pc
);

    rob_pkg::commit_state_e state;

    logic                       launch;
    logic                       ack_seen;
    logic                       misp_q;
    logic [rob_pkg::addr_w-1:0] next_pc_q;

    // present the head once it is done, never during a flush
    assign launch   = (state == rob_pkg::cm_idle) && head_ready && !flush;
    assign ack_seen = (state == rob_pkg::cm_req_high) && cm_ack;

    assign cm_req = (state == rob_pkg::cm_req_high);

    // a mispredicted branch is not freed, the flush clears it
    assign retire = ack_seen && !misp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= rob_pkg::cm_idle;
            cm_store <= 1'b0;
            misp_q   <= 1'b0;
            flush    <= 1'b0;
        end else begin
            flush <= ack_seen && misp_q;
            case (state)
                rob_pkg::cm_idle: begin
                    if (launch) begin
                        state    <= rob_pkg::cm_req_high;
                        cm_store <= (head_op == rob_pkg::op_store);
                        misp_q   <= head_mispredict;
                    end
                end
                rob_pkg::cm_req_high: begin
                    if (cm_ack) begin
                        state <= rob_pkg::cm_wait_ack_low;
                    end
                end
                rob_pkg::cm_wait_ack_low: begin
                    // four-phase return to zero before the next request
                    if (!cm_ack) begin
                        state <= rob_pkg::cm_idle;
                    end
                end
                default: begin
                    state <= rob_pkg::cm_idle;
                end
            endcase
        end
    end

    // latched head fields, held stable through the handshake
    always_ff @(posedge clk) begin
        if (launch) begin
            cm_tag    <= head_tag;
            cm_rd     <= head_rd;
            cm_data   <= head_data;
            next_pc_q <= head_next_pc;
        end
        if (ack_seen && misp_q) begin
            redirect_pc <= next_pc_q;
        end
    end

endmodule

//--- design/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // dispatch port
    input  logic                       disp_req,
    input  rob_pkg::rob_op_e           disp_op,
    input  logic [rob_pkg::reg_w-1:0]  disp_rd,
    input  logic                       disp_pred_taken,
    output logic                       disp_ack,
    output logic [rob_pkg::tag_w-1:0]  disp_tag,
    // completion port
    input  logic                       cmp_valid,
    input  logic [rob_pkg::tag_w-1:0]  cmp_tag,
    input  logic [rob_pkg::data_w-1:0] cmp_data,
    input  logic                       cmp_taken,
    input  logic [rob_pkg::addr_w-1:0] cmp_next_pc,
    // commit port
    output logic                       cm_req,
    input  logic                       cm_ack,
    output logic [rob_pkg::tag_w-1:0]  cm_tag,
    output logic [rob_pkg::reg_w-1:0]  cm_rd,
    output logic [rob_pkg::data_w-1:0] cm_data,
    output logic                       cm_store,
    // redirect on misprediction
    output logic                       flush,
    output logic [rob_pkg::addr_w-1:0] redirect_pc
);

    logic                       alloc_en;
    logic                       full;
    logic                       retire;
    logic                       head_ready;
    logic [rob_pkg::tag_w-1:0]  head_tag;
    rob_pkg::rob_op_e           head_op;
    logic [rob_pkg::reg_w-1:0]  head_rd;
    logic [rob_pkg::data_w-1:0] head_data;
    logic                       head_mispredict;
    logic [rob_pkg::addr_w-1:0] head_next_pc;

    rob_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .disp_req (disp_req),
        .full     (full),
        .flush    (flush),
        .disp_ack (disp_ack),
        .alloc_en (alloc_en)
    );

    // opcode, rd and prediction go straight into the allocated slot
    rob_buffer u_buffer (
        .clk              (clk),
        .rst_n            (rst_n),
        .alloc_en         (alloc_en),
        .alloc_op         (disp_op),
        .alloc_rd         (disp_rd),
        .alloc_pred_taken (disp_pred_taken),
        .alloc_tag        (disp_tag),
        .full             (full),
        .cmp_valid        (cmp_valid),
        .cmp_tag          (cmp_tag),
        .cmp_data         (cmp_data),
        .cmp_taken        (cmp_taken),
        .cmp_next_pc      (cmp_next_pc),
        .retire           (retire),
        .flush            (flush),
        .head_ready       (head_ready),
        .head_tag         (head_tag),
        .head_op          (head_op),
        .head_rd          (head_rd),
        .head_data        (head_data),
        .head_mispredict  (head_mispredict),
        .head_next_pc     (head_next_pc)
    );

    rob_commit u_commit (
        .clk             (clk),
        .rst_n           (rst_n),
        .head_ready      (head_ready),
        .head_tag        (head_tag),
        .head_op         (head_op),
        .head_rd         (head_rd),
        .head_data       (head_data),
        .head_mispredict (head_mispredict),
        .head_next_pc    (head_next_pc),
        .cm_req          (cm_req),
        .cm_ack          (cm_ack),
        .cm_tag          (cm_tag),
        .cm_rd           (cm_rd),
        .cm_data         (cm_data),
        .cm_store        (cm_store),
        .retire          (retire),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

endmodule

//--- sim/rob_clock_gen.sv
`timescale 1ns/1ps

module rob_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for the first eight rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/rob_properties.sv
`timescale 1ns/1ps

module rob_properties (
    input logic clk,
    input logic rst_n,
    input logic disp_req,
    input logic disp_ack,
    input logic cm_req,
    input logic cm_ack,
    input logic flush,
    input logic full,
    input logic alloc_en
);

    // four-phase sources keep asking until answered
    disp_req_held: assert property (
        @(posedge clk) disable iff (!rst_n) disp_req && !disp_ack |=> disp_req
    ) else $error("disp_req dropped before disp_ack");

    cm_req_held: assert property (
        @(posedge clk) disable iff (!rst_n) cm_req && !cm_ack |=> cm_req
    ) else $error("cm_req dropped before cm_ack");

    flush_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !flush
    ) else $error("flush held longer than one cycle");

    // no allocation into a full buffer
    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(full && alloc_en)
    ) else $error("alloc_en raised while full");

endmodule

bind rob_top rob_properties u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .disp_req (disp_req),
    .disp_ack (disp_ack),
    .cm_req   (cm_req),
    .cm_ack   (cm_ack),
    .flush    (flush),
    .full     (full),
    .alloc_en (alloc_en)
);

//--- sim/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    // one dispatched instruction and the results its completion will carry
    typedef struct packed {
        logic [rob_pkg::tag_w-1:0]  tag;
        rob_pkg::rob_op_e           op;
        logic [rob_pkg::reg_w-1:0]  rd;
        logic                       pred;
        logic                       taken;
        logic [rob_pkg::data_w-1:0] data;
        logic [rob_pkg::addr_w-1:0] next_pc;
    } entry_t;

    logic                       clk;
    logic                       rst_n;
    logic                       disp_req = 1'b0;
    rob_pkg::rob_op_e           disp_op = rob_pkg::op_alu;
    logic [rob_pkg::reg_w-1:0]  disp_rd = '0;
    logic                       disp_pred_taken = 1'b0;
    logic                       disp_ack;
    logic [rob_pkg::tag_w-1:0]  disp_tag;
    logic                       cmp_valid = 1'b0;
    logic [rob_pkg::tag_w-1:0]  cmp_tag = '0;
    logic [rob_pkg::data_w-1:0] cmp_data = '0;
    logic                       cmp_taken = 1'b0;
    logic [rob_pkg::addr_w-1:0] cmp_next_pc = '0;
    logic                       cm_req;
    logic                       cm_ack = 1'b0;
    logic [rob_pkg::tag_w-1:0]  cm_tag;
    logic [rob_pkg::reg_w-1:0]  cm_rd;
    logic [rob_pkg::data_w-1:0] cm_data;
    logic                       cm_store;
    logic                       flush;
    logic [rob_pkg::addr_w-1:0] redirect_pc;

    // reference model state
    entry_t                     issued [rob_pkg::rob_depth];
    entry_t                     exp_q [$];
    entry_t                     req_e;
    logic [rob_pkg::tag_w-1:0]  batch [$];
    logic [rob_pkg::tag_w-1:0]  next_tag = '0;
    logic [rob_pkg::addr_w-1:0] exp_redirect = '0;
    logic                       flush_expected = 1'b0;
    logic                       stall = 1'b0;
    int                         errors = 0;
    int                         commits = 0;
    int                         flushes = 0;
    int                         seed_draw;

    rob_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));
    rob_top dut (.*);

    // what the outside should see when an entry retires
    function automatic void reference_commit(input entry_t e, output logic store,
                                             output logic redirect);
        store = (e.op == rob_pkg::op_store);
        // only a branch that went against its prediction redirects
        redirect = (e.op == rob_pkg::op_branch) && (e.pred != e.taken);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // compare each acknowledged commit and each flush with the model
    always @(posedge clk) begin : check_commits
        entry_t e;
        logic store;
        logic redirect;
        if (rst_n && cm_req && cm_ack) begin
            commits++;
            if (exp_q.size() == 0) begin
                report_error("a commit arrived with no live entry left to retire");
            end else begin
                e = exp_q.pop_front();
                reference_commit(e, store, redirect);
                if (cm_tag !== e.tag) report_mismatch("cm_tag", 32'(cm_tag), 32'(e.tag));
                if (cm_rd !== e.rd) report_mismatch("cm_rd", 32'(cm_rd), 32'(e.rd));
                if (cm_data !== e.data) report_mismatch("cm_data", cm_data, e.data);
                if (cm_store !== store) report_mismatch("cm_store", 32'(cm_store), 32'(store));
                // younger entries die with the mispredicted branch
                if (redirect) begin
                    flush_expected = 1'b1;
                    exp_redirect = e.next_pc;
                    exp_q.delete();
                end
            end
        end
        if (rst_n && flush) begin
            flushes++;
            if (!flush_expected) begin
                report_error("flush raised without a mispredicted branch");
            end else if (redirect_pc !== exp_redirect) begin
                report_mismatch("redirect_pc", redirect_pc, exp_redirect);
            end
            flush_expected = 1'b0;
        end
    end

    // outside end of the commit port, ack withheld while stalled
    always @(posedge clk) begin
        if (!rst_n || cm_ack) begin
            cm_ack <= 1'b0;
        end else if (cm_req && !stall) begin
            cm_ack <= 1'b1;
        end
    end

    // full four-phase dispatch, results prepared up front for the completion
    task automatic dispatch(input rob_pkg::rob_op_e op, input logic pred, input logic taken);
        @(posedge clk);
        req_e.tag = next_tag;
        req_e.op = op;
        req_e.rd = (rob_pkg::reg_w)'($urandom);
        req_e.pred = pred;
        req_e.taken = taken;
        req_e.data = $urandom;
        req_e.next_pc = $urandom & 32'hffff_fffc;
        disp_req <= 1'b1;
        disp_op <= op;
        disp_rd <= req_e.rd;
        disp_pred_taken <= pred;
        @(posedge clk);
        while (!disp_ack) @(posedge clk);
        if (disp_tag !== req_e.tag) report_mismatch("disp_tag", 32'(disp_tag), 32'(req_e.tag));
        issued[req_e.tag] = req_e;
        exp_q.push_back(req_e);
        batch.push_back(req_e.tag);
        next_tag = next_tag + 1'b1;
        disp_req <= 1'b0;
    endtask

    task automatic complete(input logic [rob_pkg::tag_w-1:0] tag);
        @(posedge clk);
        cmp_valid <= 1'b1;
        cmp_tag <= tag;
        cmp_data <= issued[tag].data;
        cmp_taken <= issued[tag].taken;
        cmp_next_pc <= issued[tag].next_pc;
        @(posedge clk);
        cmp_valid <= 1'b0;
    endtask

    // complete everything dispatched since the last batch
    task automatic complete_batch(input logic scramble);
        int j;
        logic [rob_pkg::tag_w-1:0] t;
        for (int i = batch.size() - 1; i > 0 && scramble; i--) begin
            j = $urandom_range(i, 0);
            t = batch[i];
            batch[i] = batch[j];
            batch[j] = t;
        end
        foreach (batch[i]) complete(batch[i]);
        batch.delete();
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || flush_expected) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int mark;
        rob_pkg::rob_op_e op;
        seed_draw = $urandom(32'h677448d3);
        wait (rst_n);
        mark = errors;
        repeat (6) dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        complete_batch(1'b1);
        drain();
        finish_test("in-order retirement", mark);
        // first store and second alu fixed, the rest random
        mark = errors;
        for (int i = 0; i < 6; i++) begin
            op = (i == 0 || (i > 1 && $urandom_range(1, 0) == 1)) ? rob_pkg::op_store
                                                                  : rob_pkg::op_alu;
            dispatch(op, 1'b0, 1'b0);
        end
        complete_batch(1'b1);
        drain();
        finish_test("store release", mark);
        // fill all eight slots with commits held off
        mark = errors;
        stall <= 1'b1;
        repeat (rob_pkg::rob_depth) dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        complete_batch(1'b0);
        fork
            dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
            begin
                repeat (12) begin
                    @(posedge clk);
                    if (disp_ack) report_error("disp_ack given while the buffer was full");
                end
                stall <= 1'b0;
            end
        join
        complete_batch(1'b0);
        drain();
        finish_test("back-pressure when full", mark);
        mark = errors;
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        dispatch(rob_pkg::op_branch, 1'b1, 1'b1);
        dispatch(rob_pkg::op_branch, 1'b0, 1'b0);
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        complete_batch(1'b1);
        drain();
        finish_test("correct prediction", mark);
        // mispredicted branch in the middle, two younger entries behind it
        mark = errors;
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        dispatch(rob_pkg::op_branch, 1'b0, 1'b1);
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        complete_batch(1'b1);
        drain();
        if (flushes != 1) report_error("flush did not pulse exactly once");
        // tags restart at zero, a stale completion finds nothing
        next_tag = '0;
        complete(3'd3);
        repeat (3) dispatch(rob_pkg::op_alu, 1'b0, 1'b0);
        complete_batch(1'b1);
        drain();
        finish_test("misprediction flush", mark);
        $display("summary: %0d commits, %0d flushes, %0d errors", commits, flushes, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // test lengths in cycles, with a fourfold margin
    initial begin
        int budget;
        budget = (8 + 80 + 80 + 160 + 60 + 120) * 4;
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", budget);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- sources.f
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_buffer.sv
design/rob_commit.sv
design/rob_top.sv
sim/rob_clock_gen.sv
sim/rob_properties.sv
sim/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
